//--- files.f
+incdir+tb
hdl/cpu_pkg.sv
hdl/cpu_ifs.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/mem_lane.sv
hdl/inst_decoder.sv
hdl/pc_sequencer.sv
hdl/cpu_top.sv
tb/tb_clock.sv
tb/tb_top.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module tb_top

sim:
	verilator --binary --timing -f files.f --top-module tb_top -o tb_top_sim
	./obj_dir/tb_top_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_iss.svh
// reference model stepping one instruction on model_regs, model_ram and model_pc
task automatic model_step(input instr_t inst);
	word_t       rs_v;
	word_t       rt_v;
	word_t       simm;
	word_t       addr;
	word_t       mem_word;
	word_t       pc4;
	word_t       next_pc;
	word_t       result;
	logic [7:0]  byte_v;
	logic [15:0] half_v;
	logic        write;
	logic        taken;
	reg_addr_t   dest;
	int          nbytes;
	int          b;

	rs_v     = model_regs[inst.r.rs];
	rt_v     = model_regs[inst.r.rt];
	simm     = {{16{inst.i.imm[15]}}, inst.i.imm};
	addr     = rs_v + simm;
	mem_word = model_ram[addr[7:2]];
	byte_v   = 8'(mem_word >> (8 * addr[1:0]));
	half_v   = 16'(mem_word >> (16 * addr[1])); // bit 0 ignored
	pc4      = model_pc + 32'd4;
	next_pc  = pc4;
	result   = '0;
	taken    = 1'b0;
	nbytes   = 4;
	dest     = inst.i.rt;
	write    = inst.i.opcode inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori,
		op_lui, op_lb, op_lbu, op_lh, op_lhu, op_lw};

	exp_store = inst.i.opcode inside {op_sb, op_sh, op_sw};
	exp_addr  = {addr[31:2], 2'b00};
	exp_be    = 4'b1111;
	exp_wdata = rt_v;

	case (inst.i.opcode)
		op_special:
		begin
			dest  = inst.r.rd;
			write = 1'b1;
			case (inst.r.funct)
				fn_addu: result = rs_v + rt_v;
				fn_subu: result = rs_v - rt_v;
				fn_slt:  result = word_t'($signed(rs_v) < $signed(rt_v));
				fn_sltu: result = word_t'(rs_v < rt_v);
				fn_and:  result = rs_v & rt_v;
				fn_or:   result = rs_v | rt_v;
				fn_xor:  result = rs_v ^ rt_v;
				fn_nor:  result = ~(rs_v | rt_v);
				fn_sll:  result = rt_v << inst.r.shamt;
				fn_srl:  result = rt_v >> inst.r.shamt;
				fn_sra:  result = $signed(rt_v) >>> inst.r.shamt;
				fn_sllv: result = rt_v << rs_v[4:0];
				fn_srlv: result = rt_v >> rs_v[4:0];
				fn_srav: result = $signed(rt_v) >>> rs_v[4:0];
				default: write = 1'b0;
			endcase
		end
		op_addiu: result = rs_v + simm;
		op_slti:  result = word_t'($signed(rs_v) < $signed(simm));
		op_sltiu: result = word_t'(rs_v < simm); // sign-extended then compared unsigned
		op_andi:  result = rs_v & {16'h0000, inst.i.imm};
		op_ori:   result = rs_v | {16'h0000, inst.i.imm};
		op_xori:  result = rs_v ^ {16'h0000, inst.i.imm};
		op_lui:   result = {inst.i.imm, 16'h0000};
		op_lb:    result = {{24{byte_v[7]}}, byte_v};
		op_lbu:   result = {24'h000000, byte_v};
		op_lh:    result = {{16{half_v[15]}}, half_v};
		op_lhu:   result = {16'h0000, half_v};
		op_lw:    result = mem_word;
		op_sb:    nbytes = 1;
		op_sh:    nbytes = 2;
		op_beq:    taken = rs_v == rt_v;
		op_bne:    taken = rs_v != rt_v;
		op_blez:   taken = $signed(rs_v) <= 0;
		op_bgtz:   taken = $signed(rs_v) > 0;
		op_regimm: taken = (inst.i.rt == rt_bgez) ? !rs_v[31] : (inst.i.rt == rt_bltz && rs_v[31]);
		op_jal:
		begin
			write  = 1'b1;
			dest   = 5'd31;
			result = pc4;
		end
		default: ;
	endcase

	// each lane carries its byte of the replicated store data
	if (exp_store)
		for (b = 0; b < 4; b++)
		begin
			exp_be[b]           = (b / nbytes) == (int'(addr[1:0]) / nbytes);
			exp_wdata[8*b +: 8] = rt_v[8*(b % nbytes) +: 8];
		end

	if (taken)
		next_pc = pc4 + {simm[29:0], 2'b00};
	if (inst.j.opcode inside {op_j, op_jal})
		next_pc = {pc4[31:28], inst.j.index, 2'b00};

	exp_wb_en   = write && dest != 5'd0;
	exp_wb_addr = dest;
	exp_wb_data = result;
	if (exp_wb_en)
		model_regs[dest] = result;
	if (exp_store)
		for (b = 0; b < 4; b++)
			if (exp_be[b])
				model_ram[addr[7:2]][8*b +: 8] = exp_wdata[8*b +: 8];
	model_pc = next_pc;
endtask

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

	localparam word_t reset_pc     = 32'hbfc00000;
	localparam int    prog_len     = 200;
	localparam int    period_ns    = 8;
	localparam int    reset_cycles = 5;
	localparam int    timeout_ns   = (prog_len * 3 + reset_cycles + 40) * period_ns;
	localparam word_t last_pc      = reset_pc + 4 * (prog_len - 1);

	localparam logic [5:0] alu_fns [0:7] = '{fn_addu, fn_subu, fn_slt, fn_sltu,
		fn_and, fn_or, fn_xor, fn_nor};
	localparam logic [5:0] shift_fns [0:5] = '{fn_sll, fn_srl, fn_sra,
		fn_sllv, fn_srlv, fn_srav};
	localparam logic [5:0] imm_ops [0:6] = '{op_addiu, op_slti, op_sltiu,
		op_andi, op_ori, op_xori, op_lui};
	localparam logic [5:0] mem_ops [0:7] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw,
		op_sb, op_sh, op_sw};
	localparam logic [5:0] branch_ops [0:5] = '{op_beq, op_bne, op_blez, op_bgtz,
		op_regimm, op_regimm};

	logic       aclk;
	logic       areset_n;
	word_t      inst_addr;
	word_t      inst_rdata;
	logic       data_en;
	logic       data_we;
	logic [3:0] data_be;
	word_t      data_addr;
	word_t      data_wdata;
	word_t      data_rdata;
	logic       retire_valid;
	word_t      retire_pc;
	logic       wb_en;
	reg_addr_t  wb_addr;
	word_t      wb_data;

	word_t       rom [0:prog_len-1];
	word_t       ram [0:63];        // 256-byte data window
	word_t       model_ram [0:63];
	word_t       model_regs [0:31];
	word_t       model_pc;
	word_t       cur_pc;
	logic [31:0] rng_state;
	logic        finished;
	int          errors;

	// expected effects of the last stepped instruction
	logic       exp_wb_en;
	reg_addr_t  exp_wb_addr;
	word_t      exp_wb_data;
	logic       exp_store;
	word_t      exp_addr;
	logic [3:0] exp_be;
	word_t      exp_wdata;

	tb_clock #(
		.period_ns    (period_ns),
		.reset_cycles (reset_cycles)
	) i_tb_clock (
		.aclk     (aclk),
		.areset_n (areset_n)
	);

	cpu_top i_cpu_top (
		.aclk         (aclk),
		.areset_n     (areset_n),
		.inst_addr    (inst_addr),
		.inst_rdata   (inst_rdata),
		.data_en      (data_en),
		.data_we      (data_we),
		.data_be      (data_be),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.data_rdata   (data_rdata),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data)
	);

	`include "tb_iss.svh"

	function automatic word_t rand_word();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_t fill_word(input int idx);
		return (32'h9e3779b9 * word_t'(idx + 1)) ^ 32'h5a5a0000;
	endfunction

	function automatic word_t rom_fetch(input word_t addr);
		word_t offset;
		offset = addr - reset_pc;
		if (offset[1:0] == 2'b00 && offset < word_t'(4 * prog_len))
			return rom[int'(offset[31:2])];
		return '0; // sll r0 outside the program
	endfunction

	function automatic logic [25:0] jump_index(input int target);
		word_t addr;
		addr = reset_pc + word_t'(4 * target);
		return addr[27:2];
	endfunction

	function automatic word_t r_format(input logic [5:0] fn, input reg_addr_t rs,
		input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t i_format(input logic [5:0] op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_format(input logic [5:0] op, input logic [25:0] index);
		return {op, index};
	endfunction

	function automatic word_t random_instr(input int k);
		word_t       r;
		word_t       s;
		int          kind;
		int          pick;
		int          span;
		logic [5:0]  op;
		logic [15:0] imm;
		reg_addr_t   rt;
		r    = rand_word();
		s    = rand_word();
		kind = int'(r[7:0]) % 16;
		pick = int'(r[15:8]);
		if (kind < 4)
			return r_format(alu_fns[pick % 8], s[4:0], s[9:5], s[14:10], 5'd0);
		if (kind < 6)
			return r_format(shift_fns[pick % 6], s[4:0], s[9:5], s[14:10], s[19:15]);
		if (kind < 9)
			return i_format(imm_ops[pick % 7], s[4:0], s[9:5], s[31:16]);
		if (kind < 12)
		begin
			op  = mem_ops[pick % 8];
			imm = {8'h00, s[23:16] & (op[1] ? 8'hfc : (op[0] ? 8'hfe : 8'hff))}; // aligned
			return i_format(op, 5'd0, s[9:5], imm);
		end
		if (kind < 15)
		begin
			op   = branch_ops[pick % 6];
			span = prog_len - 2 - k; // forward only and never past the last word
			if (span > 12)
				span = 12;
			imm = 16'(int'(s[23:16]) % (span + 1));
			case (pick % 6)
				0, 1:    rt = r[16] ? s[4:0] : s[9:5]; // equal operands now and then
				5:       rt = rt_bgez;
				default: rt = rt_bltz;
			endcase
			return i_format(op, s[4:0], rt, imm);
		end
		return j_format(r[16] ? op_jal : op_j,
			jump_index(k + 1 + int'(s[15:0]) % (prog_len - 1 - k)));
	endfunction

	task automatic build_program();
		int    k;
		word_t s;
		for (k = 0; k < prog_len; k++)
		begin
			s = rand_word();
			if (k < 31)
				rom[k] = i_format(op_addiu, 5'd0, reg_addr_t'(k + 1), s[15:0]); // seed r1..r31
			else if (k == prog_len - 1)
				rom[k] = j_format(op_j, jump_index(k)); // self-loop
			else
				rom[k] = random_instr(k);
		end
	endtask

	task automatic check_value(input string what, input word_t got, input word_t want);
		if (got !== want)
		begin
			errors++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// ROM and RAM answer on the falling edge
	always @(negedge aclk)
	begin
		inst_rdata <= rom_fetch(inst_addr);
		if (data_en && !data_we)
			data_rdata <= ram[data_addr[7:2]];
	end

	always @(posedge aclk)
	begin
		if (data_we)
			for (int b = 0; b < 4; b++)
				if (data_be[b])
					ram[data_addr[7:2]][8*b +: 8] <= data_wdata[8*b +: 8];
	end

	always @(negedge aclk)
	begin
		if (areset_n && retire_valid)
		begin
			check_value("retire_pc", retire_pc, model_pc);
			check_value("inst_addr", inst_addr, model_pc);
			cur_pc = model_pc;
			model_step(rom_fetch(model_pc));
			check_value("wb_en", word_t'(wb_en), word_t'(exp_wb_en));
			if (exp_wb_en)
			begin
				check_value("wb_addr", word_t'(wb_addr), word_t'(exp_wb_addr));
				check_value("wb_data", wb_data, exp_wb_data);
			end
			check_value("data_we", word_t'(data_we), word_t'(exp_store));
			check_value("data_en", word_t'(data_en), word_t'(exp_store));
			if (exp_store)
			begin
				check_value("data_addr", data_addr, exp_addr);
				check_value("data_be", word_t'(data_be), word_t'(exp_be));
				check_value("data_wdata", data_wdata, exp_wdata);
			end
			if (cur_pc == last_pc)
				finished = 1'b1;
		end
	end

	initial
	begin
		inst_rdata = '0;
		data_rdata = '0;
		rng_state  = 32'hff338269;
		finished   = 1'b0;
		errors     = 0;
		model_pc   = reset_pc;
		for (int i = 0; i < 64; i++)
		begin
			ram[i]       = fill_word(i);
			model_ram[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		build_program();
		wait (finished);
		if (errors == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	initial
	begin
		#(timeout_ns);
		$display("timeout: the final jump had not retired after %0d ns", timeout_ns);
		$display("SOME TESTS FAILED");
		$fatal(1);
	end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns    = 8,
	parameter int reset_cycles = 5
) (
	output logic aclk,
	output logic areset_n
);

	initial
	begin
		aclk = 1'b0;
		forever #(period_ns / 2) aclk = ~aclk;
	end

	initial
	begin
		areset_n = 1'b0;
		repeat (reset_cycles) @(posedge aclk);
		@(negedge aclk);
		areset_n <= 1'b1; // released on a falling edge
	end

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter word_t reset_pc = 32'hbfc00000
) (
	input  logic      aclk,
	input  logic      areset_n,

	output word_t     inst_addr,
	input  word_t     inst_rdata,

	output logic      data_en,
	output logic      data_we,
	output logic [3:0] data_be,
	output word_t     data_addr,
	output word_t     data_wdata,
	input  word_t     data_rdata,

	output logic      retire_valid,
	output word_t     retire_pc,
	output logic      wb_en,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	decode_if ctrl_bus();
	rf_if     rf_bus();

	instr_t inst;
	word_t  pc;
	word_t  link_addr;
	word_t  alu_result;
	word_t  load_value;
	logic   in_exec;
	logic   retire;

	assign inst = inst_rdata; // memory holds it through EXEC and LOAD

	inst_decoder i_inst_decoder (
		.inst (inst),
		.ctrl (ctrl_bus.producer),
		.rf   (rf_bus.dec)
	);

	reg_file i_reg_file (
		.aclk (aclk),
		.rf   (rf_bus.regs)
	);

	alu i_alu (
		.ctrl   (ctrl_bus.consumer),
		.rs_val (rf_bus.rdata0),
		.rt_val (rf_bus.rdata1),
		.imm    (inst.i.imm),
		.shamt  (inst.r.shamt),
		.result (alu_result)
	);

	mem_lane i_mem_lane (
		.ctrl       (ctrl_bus.consumer),
		.addr_low   (alu_result[1:0]),
		.rt_val     (rf_bus.rdata1),
		.data_rdata (data_rdata),
		.data_be    (data_be),
		.data_wdata (data_wdata),
		.load_value (load_value)
	);

	pc_sequencer #(
		.reset_pc (reset_pc)
	) i_pc_sequencer (
		.aclk      (aclk),
		.areset_n  (areset_n),
		.inst      (inst),
		.ctrl      (ctrl_bus.consumer),
		.rs_val    (rf_bus.rdata0),
		.rt_val    (rf_bus.rdata1),
		.pc        (pc),
		.link_addr (link_addr),
		.in_exec   (in_exec),
		.retire    (retire)
	);

	assign inst_addr = pc;
	assign data_addr = {alu_result[xlen-1:2], 2'b00}; // lanes picked by data_be
	assign data_en   = in_exec & (ctrl_bus.is_load | ctrl_bus.is_store);
	assign data_we   = in_exec & ctrl_bus.is_store;

	always_comb
	begin
		case (ctrl_bus.wb_sel)
			wb_mem:  wb_data = load_value;
			wb_link: wb_data = link_addr;
			default: wb_data = alu_result;
		endcase
	end

	assign wb_en   = retire & ctrl_bus.reg_write_req;
	assign wb_addr = ctrl_bus.dest;

	assign rf_bus.we    = wb_en;
	assign rf_bus.waddr = wb_addr;
	assign rf_bus.wdata = wb_data;

	assign retire_valid = retire;
	assign retire_pc    = pc;

endmodule

//--- hdl/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer import cpu_pkg::*; #(
	parameter word_t reset_pc = 32'hbfc00000
) (
	input  logic   aclk,
	input  logic   areset_n,
	input  instr_t inst,
	decode_if.consumer ctrl,
	input  word_t  rs_val,
	input  word_t  rt_val,
	output word_t  pc,
	output word_t  link_addr,
	output logic   in_exec,
	output logic   retire
);

	localparam logic [1:0] st_fetch = 2'd0;
	localparam logic [1:0] st_exec  = 2'd1;
	localparam logic [1:0] st_load  = 2'd2;

	logic [1:0] state;
	word_t      pc_plus4;
	word_t      branch_target;
	word_t      jump_target;
	word_t      next_pc;
	logic       taken;

	assign pc_plus4  = pc + 32'd4;
	assign link_addr = pc_plus4;

	assign branch_target = pc_plus4 + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
	assign jump_target   = {pc_plus4[31:28], inst.j.index, 2'b00}; // same 256MB region

	always_comb
	begin
		case (ctrl.branch)
			br_eq:   taken = rs_val == rt_val;
			br_ne:   taken = rs_val != rt_val;
			br_gez:  taken = !rs_val[31];
			br_gtz:  taken = !rs_val[31] && rs_val != '0;
			br_lez:  taken = rs_val[31] || rs_val == '0;
			br_ltz:  taken = rs_val[31];
			br_jump: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (ctrl.branch == br_jump)
			next_pc = jump_target;
		else if (taken)
			next_pc = branch_target;
		else
			next_pc = pc_plus4;
	end

	assign in_exec = state == st_exec;
	assign retire  = (in_exec && !ctrl.is_load) || state == st_load;

	always_ff @(posedge aclk)
	begin
		if (!areset_n)
		begin
			state <= st_fetch;
			pc    <= reset_pc;
		end
		else
		begin
			case (state)
				st_fetch: state <= st_exec;
				st_exec:  state <= ctrl.is_load ? st_load : st_fetch;
				default:  state <= st_fetch;
			endcase
			if (retire)
				pc <= next_pc;
		end
	end

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import cpu_pkg::*; (
	input  instr_t inst,
	decode_if.producer ctrl,
	rf_if.dec rf
);

	logic      imm_alu;
	logic      is_load;
	logic      is_store;
	logic      write;
	reg_addr_t dest;
	alu_op_e   alu_op;
	branch_e   branch;

	assign imm_alu = inst.i.opcode inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori,
		op_xori, op_lui};
	assign is_load  = inst.i.opcode inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
	assign is_store = inst.i.opcode inside {op_sb, op_sh, op_sw};

	always_comb
	begin
		alu_op = alu_add; // loads and stores use it for the address
		write  = 1'b0;
		dest   = inst.r.rd;
		branch = br_none;
		case (inst.r.opcode)
			op_special:
			begin
				write = 1'b1;
				case (inst.r.funct)
					fn_sll, fn_sllv: alu_op = alu_sll;
					fn_srl, fn_srlv: alu_op = alu_srl;
					fn_sra, fn_srav: alu_op = alu_sra;
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_nor:  alu_op = alu_nor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					default: write = 1'b0;
				endcase
			end
			op_regimm:
				if (inst.i.rt == rt_bltz)
					branch = br_ltz;
				else if (inst.i.rt == rt_bgez)
					branch = br_gez;
			op_j: branch = br_jump;
			op_jal:
			begin
				branch = br_jump;
				write  = 1'b1;
				dest   = 5'd31;
			end
			op_beq:   branch = br_eq;
			op_bne:   branch = br_ne;
			op_blez:  branch = br_lez;
			op_bgtz:  branch = br_gtz;
			op_slti:  alu_op = alu_slt;
			op_sltiu: alu_op = alu_sltu;
			op_andi:  alu_op = alu_and;
			op_ori:   alu_op = alu_or;
			op_xori:  alu_op = alu_xor;
			op_lui:   alu_op = alu_lui;
			default: ;
		endcase
		if (imm_alu || is_load)
		begin
			write = 1'b1;
			dest  = inst.i.rt;
		end
	end

	assign ctrl.alu_op        = alu_op;
	assign ctrl.use_imm       = imm_alu | is_load | is_store;
	assign ctrl.imm_signed    = !(inst.i.opcode inside {op_andi, op_ori, op_xori});
	assign ctrl.shamt_var     = inst.r.funct[2]; // sllv, srlv, srav
	assign ctrl.wb_sel        = is_load ? wb_mem : (inst.j.opcode == op_jal ? wb_link : wb_alu);
	assign ctrl.dest          = dest;
	assign ctrl.reg_write_req = write && dest != '0;
	assign ctrl.is_load       = is_load;
	assign ctrl.is_store      = is_store;
	// size sits in opcode[1:0], unsigned flag in opcode[2]
	assign ctrl.mem_size      = inst.i.opcode[1] ? size_word
		: (inst.i.opcode[0] ? size_half : size_byte);
	assign ctrl.load_unsigned = inst.i.opcode[2];
	assign ctrl.branch        = branch;

	assign rf.raddr0 = inst.r.rs;
	assign rf.raddr1 = inst.r.rt;

endmodule

//--- hdl/mem_lane.sv
`timescale 1ns/1ps

module mem_lane import cpu_pkg::*; (
	decode_if.consumer ctrl,
	input  logic [1:0] addr_low,
	input  word_t      rt_val,
	input  word_t      data_rdata,
	output logic [3:0] data_be,
	output word_t      data_wdata,
	output word_t      load_value
);

	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	always_comb
	begin
		case (ctrl.mem_size)
			size_byte:
			begin
				data_be    = 4'b0001 << addr_low;
				data_wdata = {4{rt_val[7:0]}};
			end
			size_half:
			begin
				data_be    = addr_low[1] ? 4'b1100 : 4'b0011; // addr bit 0 ignored
				data_wdata = {2{rt_val[15:0]}};
			end
			default:
			begin
				data_be    = 4'b1111;
				data_wdata = rt_val;
			end
		endcase
	end

	assign byte_sel = data_rdata[8*addr_low +: 8];
	assign half_sel = addr_low[1] ? data_rdata[31:16] : data_rdata[15:0];

	always_comb
	begin
		case (ctrl.mem_size)
			size_byte: load_value = {{24{!ctrl.load_unsigned & byte_sel[7]}}, byte_sel};
			size_half: load_value = {{16{!ctrl.load_unsigned & half_sel[15]}}, half_sel};
			default:   load_value = data_rdata;
		endcase
	end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	decode_if.consumer ctrl,
	input  word_t       rs_val,
	input  word_t       rt_val,
	input  logic [15:0] imm,
	input  logic [4:0]  shamt,
	output word_t       result
);

	word_t       ext_imm;
	word_t       op_b;
	logic        subtract;
	logic [xlen:0] sum;
	logic        lt_signed;
	logic        lt_unsigned;
	logic        shift_left;
	logic        fill;
	logic [4:0]  shift_amt;
	word_t       stage [0:5];

	assign ext_imm  = {{16{ctrl.imm_signed & imm[15]}}, imm};
	assign op_b     = ctrl.use_imm ? ext_imm : rt_val;
	assign subtract = ctrl.alu_op inside {alu_sub, alu_slt, alu_sltu};

	// a - b as a + ~b + 1, carry out kept for the unsigned compare
	assign sum = {1'b0, rs_val} + {1'b0, subtract ? ~op_b : op_b} + {{xlen{1'b0}}, subtract};
	assign lt_unsigned = !sum[xlen];
	assign lt_signed   = (rs_val[xlen-1] != op_b[xlen-1]) ? rs_val[xlen-1] : sum[xlen-1];

	// right shifter, left shifts go through bit reversal
	assign shift_left = ctrl.alu_op == alu_sll;
	assign fill       = ctrl.alu_op == alu_sra && rt_val[xlen-1];
	assign shift_amt  = ctrl.shamt_var ? rs_val[4:0] : shamt;
	assign stage[0]   = shift_left ? {<<{rt_val}} : rt_val;

	for (genvar k = 0; k < 5; k++)
	begin : g_shift
		assign stage[k+1] = shift_amt[k] ? {{(2**k){fill}}, stage[k][xlen-1:2**k]} : stage[k];
	end

	always_comb
	begin
		case (ctrl.alu_op)
			alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
			alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
			alu_and:  result = rs_val & op_b;
			alu_or:   result = rs_val | op_b;
			alu_xor:  result = rs_val ^ op_b;
			alu_nor:  result = ~(rs_val | op_b);
			alu_sll:  result = {<<{stage[5]}};
			alu_srl, alu_sra: result = stage[5];
			alu_lui:  result = {imm, 16'h0000};
			default:  result = sum[xlen-1:0]; // add, sub
		endcase
	end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input logic aclk,
	rf_if.regs  rf
);

	word_t regs [0:31];

	always_ff @(posedge aclk)
	begin
		if (rf.we && rf.waddr != '0)
			regs[rf.waddr] <= rf.wdata;
	end

	// r0 is hardwired
	assign rf.rdata0 = (rf.raddr0 == '0) ? '0 : regs[rf.raddr0];
	assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];

endmodule

//--- hdl/cpu_ifs.sv
`timescale 1ns/1ps

interface decode_if import cpu_pkg::*; ();
	alu_op_e   alu_op;
	logic      use_imm;
	logic      imm_signed;    // sign or zero extend imm
	logic      shamt_var;     // shift count from rs
	wb_sel_e   wb_sel;
	reg_addr_t dest;
	logic      reg_write_req;
	logic      is_load;
	logic      is_store;
	mem_size_e mem_size;
	logic      load_unsigned;
	branch_e   branch;

	modport producer (
		output alu_op, use_imm, imm_signed, shamt_var, wb_sel, dest, reg_write_req,
		output is_load, is_store, mem_size, load_unsigned, branch
	);

	modport consumer (
		input alu_op, use_imm, imm_signed, shamt_var, wb_sel, dest, reg_write_req,
		input is_load, is_store, mem_size, load_unsigned, branch
	);
endinterface

interface rf_if import cpu_pkg::*; ();
	reg_addr_t raddr0;
	reg_addr_t raddr1;
	word_t     rdata0;
	word_t     rdata1;
	logic      we;
	reg_addr_t waddr;
	word_t     wdata;

	modport dec (output raddr0, raddr1);

	modport regs (
		input raddr0, raddr1, we, waddr, wdata,
		output rdata0, rdata1
	);
endinterface

//--- hdl/cpu_pkg.sv
package cpu_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// major opcodes, bits 31:26
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_regimm  = 6'h01,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_blez    = 6'h06,
		op_bgtz    = 6'h07,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lh      = 6'h21,
		op_lw      = 6'h23,
		op_lbu     = 6'h24,
		op_lhu     = 6'h25,
		op_sb      = 6'h28,
		op_sh      = 6'h29,
		op_sw      = 6'h2b
	} opcode_e;

	// special function codes, bits 5:0
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_sra  = 6'h03,
		fn_sllv = 6'h04,
		fn_srlv = 6'h06,
		fn_srav = 6'h07,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	localparam reg_addr_t rt_bltz = 5'd0; // regimm selectors in rt
	localparam reg_addr_t rt_bgez = 5'd1;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_and, alu_or, alu_xor, alu_nor,
		alu_sll, alu_srl, alu_sra, alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_e;

	typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

	typedef enum logic [2:0] {
		br_none, br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz, br_jump
	} branch_e;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

endpackage
